//--- verilog/snd_bus_pkg.sv
/*
 * sound-side bus definitions
 * address and data types, register map of the sound board
 */
`default_nettype none

package snd_bus_pkg;

    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // tone block, offsets 0..5
    localparam bus_addr_t TONE_BASE = 8'h00;

    // pcm block, offsets 0..6
    localparam bus_addr_t PCM_BASE = 8'h10;

    localparam bus_addr_t MBOX_DATA   = 8'h20; // read clears the full flag
    localparam bus_addr_t MBOX_STATUS = 8'h21; // bit 0 is the full flag

    localparam bus_data_t OPEN_BUS = 8'hff; // unmapped reads

endpackage

`default_nettype wire

//--- verilog/snd_audio_pkg.sv
/*
 * audio types and constants
 * sample and gain types, sample ROM address, fxlevel gain table,
 * PCM fetch states
 */
`default_nettype none

package snd_audio_pkg;

    typedef logic signed [15:0] sample_t;
    typedef logic [7:0] gain_t; // 4.4 fixed point
    typedef logic [18:0] pcm_addr_t;

    localparam gain_t FM_GAIN = 8'h08; // one half

    // pcm gain selected by fxlevel
    localparam gain_t PCM_GAIN0 = 8'h02;
    localparam gain_t PCM_GAIN1 = 8'h04;
    localparam gain_t PCM_GAIN2 = 8'h08;
    localparam gain_t PCM_GAIN3 = 8'h14;

    typedef enum logic [1:0] {
        idle,     // nothing pending on the ROM
        fetch,    // address set up, request goes out next
        wait_rom  // rom_cs high until rom_ok
    } pcm_state_t;

endpackage

`default_nettype wire

//--- verilog/snd_bus_decode.sv
/*
 * Wishbone slave of the sound bus
 * address decode, single-cycle ack, block strobes, registered read mux
 */
`default_nettype none

module snd_bus_decode (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire snd_bus_pkg::bus_addr_t wb_adr,
    input  wire snd_bus_pkg::bus_data_t wb_dat_w,
    input  wire snd_bus_pkg::bus_data_t tone_dout,
    input  wire snd_bus_pkg::bus_data_t pcm_dout,
    input  wire snd_bus_pkg::bus_data_t mbox_dout,
    output logic                     wb_ack,
    output snd_bus_pkg::bus_data_t   wb_dat_r,
    output logic [2:0]               reg_addr,
    output snd_bus_pkg::bus_data_t   reg_din,
    output logic                     tone_we,
    output logic                     pcm_we,
    output logic                     mbox_rd
);

    logic access;
    logic tone_sel;
    logic pcm_sel;
    logic mbox_sel;

    // first clock of a cycle, ack not yet given
    assign access = wb_cyc & wb_stb & ~wb_ack;

    // tone offsets 6 and 7 and pcm offset 7 are unmapped
    assign tone_sel = (wb_adr[7:3] == snd_bus_pkg::TONE_BASE[7:3]) && (wb_adr[2:1] != 2'b11);
    assign pcm_sel  = (wb_adr[7:3] == snd_bus_pkg::PCM_BASE[7:3]) && (wb_adr[2:0] != 3'd7);
    assign mbox_sel = (wb_adr == snd_bus_pkg::MBOX_DATA) || (wb_adr == snd_bus_pkg::MBOX_STATUS);

    assign reg_addr = wb_adr[2:0];
    assign reg_din  = wb_dat_w;

    // strobes land on the edge that raises wb_ack
    assign tone_we = access & wb_we & tone_sel;
    assign pcm_we  = access & wb_we & pcm_sel;
    assign mbox_rd = access & ~wb_we & mbox_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access; // one clock, no wait states
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= tone_sel ? tone_dout :
                        pcm_sel  ? pcm_dout  :
                        mbox_sel ? mbox_dout :
                        snd_bus_pkg::OPEN_BUS;
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_mailbox.sv
/*
 * command mailbox from the main CPU
 * data latch, buffer-full flag and sound CPU interrupt
 */
`default_nettype none

module snd_mailbox (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         main_wr,
    input  wire snd_bus_pkg::bus_data_t main_din,
    input  wire                         mbox_rd,
    input  wire                         reg_sel,   // 0 data, 1 status
    output snd_bus_pkg::bus_data_t      mbox_dout,
    output logic                        mbox_full,
    output logic                        snd_irq
);

    snd_bus_pkg::bus_data_t cmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd       <= '0;
            mbox_full <= 1'b0;
        end else begin
            if (main_wr) begin
                cmd       <= main_din; // overwrites an unread command
                mbox_full <= 1'b1;
            end else if (mbox_rd && !reg_sel) begin
                mbox_full <= 1'b0;
            end
        end
    end

    assign mbox_dout = reg_sel ? {7'd0, mbox_full} : cmd;

    // irq stays up while a command waits
    assign snd_irq = mbox_full;

endmodule

`default_nettype wire

//--- verilog/snd_tone.sv
/*
 * two-channel square-wave tone generator
 * period and amplitude registers per channel, tick-counted phase
 */
`default_nettype none

module snd_tone (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cen_snd,
    input  wire                         tone_we,
    input  wire [2:0]                   reg_addr,
    input  wire snd_bus_pkg::bus_data_t reg_din,
    input  wire                         enable_fm,
    output snd_bus_pkg::bus_data_t      tone_dout,
    output snd_audio_pkg::sample_t     tone_left,
    output snd_audio_pkg::sample_t     tone_right
);

    logic [15:0]            period [2];  // 0 left, 1 right
    logic [7:0]             amp [2];
    logic [15:0]            cnt [2];
    logic                   phase [2];
    logic                   wrap [2];
    snd_audio_pkg::sample_t tone_out [2];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wrap[i] = (period[i] != 16'd0) && (cnt[i] == period[i] - 16'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                period[i]   <= '0;
                amp[i]      <= '0;
                cnt[i]      <= '0;
                phase[i]    <= 1'b0;
                tone_out[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cen_snd && period[i] != 16'd0) begin
                    cnt[i]   <= wrap[i] ? 16'd0 : cnt[i] + 16'd1;
                    phase[i] <= phase[i] ^ wrap[i];
                end
                if (cen_snd) begin
                    if (!enable_fm || period[i] == 16'd0)
                        tone_out[i] <= '0;
                    else if (phase[i] ^ wrap[i])
                        tone_out[i] <= {1'b0, amp[i], 7'd0};  // +amp * 128
                    else
                        tone_out[i] <= -$signed({1'b0, amp[i], 7'd0});
                end
            end
            if (tone_we) begin
                case (reg_addr)
                    3'd0, 3'd2: period[reg_addr[1]][7:0]  <= reg_din;
                    3'd1, 3'd3: period[reg_addr[1]][15:8] <= reg_din;
                    3'd4: amp[0] <= reg_din;
                    3'd5: amp[1] <= reg_din;
                    default: ;
                endcase
                if (!reg_addr[2]) begin // period write restarts the channel
                    cnt[reg_addr[1]]   <= '0;
                    phase[reg_addr[1]] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (reg_addr)
            3'd0, 3'd2: tone_dout = period[reg_addr[1]][7:0];
            3'd1, 3'd3: tone_dout = period[reg_addr[1]][15:8];
            3'd4:    tone_dout = amp[0];
            3'd5:    tone_dout = amp[1];
            default: tone_dout = '0;
        endcase
    end

    assign tone_left  = tone_out[0];
    assign tone_right = tone_out[1];

endmodule

`default_nettype wire

//--- verilog/snd_pcm.sv
/*
 * single-channel PCM sample player
 * start/end address and control registers, sample ROM fetch FSM
 */
`default_nettype none

module snd_pcm (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cen_snd,
    input  wire                         pcm_we,
    input  wire [2:0]                   reg_addr,
    input  wire snd_bus_pkg::bus_data_t reg_din,
    input  wire snd_bus_pkg::bus_data_t rom_data,
    input  wire                         rom_ok,
    output snd_bus_pkg::bus_data_t      pcm_dout,
    output snd_audio_pkg::sample_t     pcm_out,
    output snd_audio_pkg::pcm_addr_t   rom_addr,
    output logic                        rom_cs
);

    snd_audio_pkg::pcm_addr_t  start_addr;
    snd_audio_pkg::pcm_addr_t  end_addr;
    snd_audio_pkg::pcm_addr_t  addr;
    snd_audio_pkg::pcm_state_t state;
    snd_bus_pkg::bus_data_t    smp;      // byte for the next tick
    logic                      play;

    assign rom_addr = addr;
    assign rom_cs   = (state == snd_audio_pkg::wait_rom);

    always_ff @(posedge clk) begin
        if (reset) begin
            start_addr <= '0;
            end_addr   <= '0;
            addr       <= '0;
            smp        <= '0;
            play       <= 1'b0;
            pcm_out    <= '0;
            state      <= snd_audio_pkg::idle;
        end else begin
            case (state)
                snd_audio_pkg::fetch: state <= snd_audio_pkg::wait_rom;
                snd_audio_pkg::wait_rom:
                    if (rom_ok) begin
                        smp   <= rom_data;
                        state <= snd_audio_pkg::idle;
                    end
                default: ;
            endcase

            if (cen_snd) begin
                if (!play) begin
                    pcm_out <= '0;
                end else if (state == snd_audio_pkg::idle) begin
                    pcm_out <= {~smp[7], smp[6:0], 8'd0}; // (byte - 128) << 8
                    if (addr == end_addr) begin
                        play <= 1'b0; // last byte is out
                    end else begin
                        addr  <= addr + 19'd1;
                        state <= snd_audio_pkg::fetch;
                    end
                end
            end

            if (pcm_we) begin
                case (reg_addr)
                    3'd0: start_addr[7:0]   <= reg_din;
                    3'd1: start_addr[15:8]  <= reg_din;
                    3'd2: start_addr[18:16] <= reg_din[2:0];
                    3'd3: end_addr[7:0]     <= reg_din;
                    3'd4: end_addr[15:8]    <= reg_din;
                    3'd5: end_addr[18:16]   <= reg_din[2:0];
                    3'd6: begin
                        play <= reg_din[0];
                        // a request already on the ROM port is left to finish
                        if (reg_din[0] && state != snd_audio_pkg::wait_rom) begin
                            addr  <= start_addr;
                            state <= snd_audio_pkg::fetch;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_addr)
            3'd0:    pcm_dout = start_addr[7:0];
            3'd1:    pcm_dout = start_addr[15:8];
            3'd2:    pcm_dout = {5'd0, start_addr[18:16]};
            3'd3:    pcm_dout = end_addr[7:0];
            3'd4:    pcm_dout = end_addr[15:8];
            3'd5:    pcm_dout = {5'd0, end_addr[18:16]};
            3'd6:    pcm_dout = {7'd0, play};
            default: pcm_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/snd_mixer.sv
/*
 * stereo mixer
 * 4.4 gains for tone and PCM, sum, 16-bit clipping, peak and sample strobe
 */
`default_nettype none

module snd_mixer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cen_snd,
    input  wire snd_audio_pkg::sample_t tone_left,
    input  wire snd_audio_pkg::sample_t tone_right,
    input  wire snd_audio_pkg::sample_t pcm_out,
    input  wire [1:0]                   fxlevel,
    input  wire                         enable_fm,
    input  wire                         enable_pcm,
    output snd_audio_pkg::sample_t     snd_left,
    output snd_audio_pkg::sample_t     snd_right,
    output logic                        sample,
    output logic                        peak
);

    snd_audio_pkg::gain_t fm_gain;
    snd_audio_pkg::gain_t pcm_gain;
    logic                 cen_d;    // sources settle on the tick edge
    logic signed [21:0]   mix_l;
    logic signed [21:0]   mix_r;
    logic                 clip_l;
    logic                 clip_r;

    assign fm_gain = enable_fm ? snd_audio_pkg::FM_GAIN : 8'h00;

    always_comb begin
        case (fxlevel)
            2'd0:    pcm_gain = snd_audio_pkg::PCM_GAIN0;
            2'd1:    pcm_gain = snd_audio_pkg::PCM_GAIN1;
            2'd2:    pcm_gain = snd_audio_pkg::PCM_GAIN2;
            default: pcm_gain = snd_audio_pkg::PCM_GAIN3;
        endcase
        if (!enable_pcm) pcm_gain = 8'h00;
    end

    // tone * fm gain + pcm * pcm gain, back to integer scale
    function automatic logic signed [21:0] mix(input snd_audio_pkg::sample_t tone,
                                               input snd_audio_pkg::sample_t pcm,
                                               input snd_audio_pkg::gain_t g_fm,
                                               input snd_audio_pkg::gain_t g_pcm);
        logic signed [25:0] acc;
        acc = 26'(tone) * 26'($signed({1'b0, g_fm}))
            + 26'(pcm) * 26'($signed({1'b0, g_pcm}));
        return 22'(acc >>> 4);
    endfunction

    function automatic snd_audio_pkg::sample_t sat(input logic signed [21:0] v);
        if (v > 22'sd32767)
            return 16'sh7fff;
        else if (v < -22'sd32768)
            return 16'sh8000;
        else
            return v[15:0];
    endfunction

    assign mix_l  = mix(tone_left, pcm_out, fm_gain, pcm_gain);
    assign mix_r  = mix(tone_right, pcm_out, fm_gain, pcm_gain);
    assign clip_l = (mix_l > 22'sd32767) || (mix_l < -22'sd32768);
    assign clip_r = (mix_r > 22'sd32767) || (mix_r < -22'sd32768);

    always_ff @(posedge clk) begin
        if (reset) begin
            cen_d     <= 1'b0;
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
            peak      <= 1'b0;
        end else begin
            cen_d  <= cen_snd;
            sample <= cen_d;
            peak   <= cen_d & (clip_l | clip_r); // with the sample strobe
            if (cen_d) begin
                snd_left  <= sat(mix_l);
                snd_right <= sat(mix_r);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_board.sv
/*
 * sound board top level
 * bus decoder, mailbox, tone generator, PCM player and mixer
 */
`default_nettype none

module snd_board (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cen_snd,
    // sound CPU bus
    input  wire                            wb_cyc,
    input  wire                            wb_stb,
    input  wire                            wb_we,
    input  wire snd_bus_pkg::bus_addr_t    wb_adr,
    input  wire snd_bus_pkg::bus_data_t    wb_dat_w,
    output snd_bus_pkg::bus_data_t         wb_dat_r,
    output logic                           wb_ack,
    // main CPU side
    input  wire                            main_wr,
    input  wire snd_bus_pkg::bus_data_t    main_din,
    output logic                           mbox_full,
    output logic                           snd_irq,
    // sample ROM
    output snd_audio_pkg::pcm_addr_t      rom_addr,
    output logic                           rom_cs,
    input  wire snd_bus_pkg::bus_data_t    rom_data,
    input  wire                            rom_ok,
    // options
    input  wire [1:0]                      fxlevel,
    input  wire                            enable_fm,
    input  wire                            enable_pcm,
    // audio
    output snd_audio_pkg::sample_t        snd_left,
    output snd_audio_pkg::sample_t        snd_right,
    output logic                           sample,
    output logic                           peak
);

    logic [2:0]             reg_addr;
    snd_bus_pkg::bus_data_t reg_din;
    snd_bus_pkg::bus_data_t tone_dout;
    snd_bus_pkg::bus_data_t pcm_dout;
    snd_bus_pkg::bus_data_t mbox_dout;
    logic                   tone_we;
    logic                   pcm_we;
    logic                   mbox_rd;
    snd_audio_pkg::sample_t tone_left;
    snd_audio_pkg::sample_t tone_right;
    snd_audio_pkg::sample_t pcm_out;

    snd_bus_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .tone_dout (tone_dout),
        .pcm_dout  (pcm_dout),
        .mbox_dout (mbox_dout),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .reg_addr  (reg_addr),
        .reg_din   (reg_din),
        .tone_we   (tone_we),
        .pcm_we    (pcm_we),
        .mbox_rd   (mbox_rd)
    );

    snd_mailbox u_mailbox (
        .clk       (clk),
        .reset     (reset),
        .main_wr   (main_wr),
        .main_din  (main_din),
        .mbox_rd   (mbox_rd),
        .reg_sel   (reg_addr[0]),   // status at the odd address
        .mbox_dout (mbox_dout),
        .mbox_full (mbox_full),
        .snd_irq   (snd_irq)
    );

    snd_tone u_tone (
        .clk        (clk),
        .reset      (reset),
        .cen_snd    (cen_snd),
        .tone_we    (tone_we),
        .reg_addr   (reg_addr),
        .reg_din    (reg_din),
        .enable_fm  (enable_fm),
        .tone_dout  (tone_dout),
        .tone_left  (tone_left),
        .tone_right (tone_right)
    );

    snd_pcm u_pcm (
        .clk      (clk),
        .reset    (reset),
        .cen_snd  (cen_snd),
        .pcm_we   (pcm_we),
        .reg_addr (reg_addr),
        .reg_din  (reg_din),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pcm_dout (pcm_dout),
        .pcm_out  (pcm_out),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs)
    );

    snd_mixer u_mixer (
        .clk        (clk),
        .reset      (reset),
        .cen_snd    (cen_snd),
        .tone_left  (tone_left),
        .tone_right (tone_right),
        .pcm_out    (pcm_out),
        .fxlevel    (fxlevel),
        .enable_fm  (enable_fm),
        .enable_pcm (enable_pcm),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .sample     (sample),
        .peak       (peak)
    );

endmodule

`default_nettype wire

//--- testbench/snd_board_tb.sv
/*
 * sound board testbench
 * clock and reset, vector file interpreter, sample ROM and main CPU models
 */
`default_nettype none

module snd_board_tb;

    logic                     clk;
    logic                     reset;
    logic                     cen_snd;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    snd_bus_pkg::bus_addr_t   wb_adr;
    snd_bus_pkg::bus_data_t   wb_dat_w;
    snd_bus_pkg::bus_data_t   wb_dat_r;
    logic                     wb_ack;
    logic                     main_wr;
    snd_bus_pkg::bus_data_t   main_din;
    logic                     mbox_full;
    logic                     snd_irq;
    snd_audio_pkg::pcm_addr_t rom_addr;
    logic                     rom_cs;
    snd_bus_pkg::bus_data_t   rom_data;
    logic                     rom_ok;
    logic [1:0]               fxlevel;
    logic                     enable_fm;
    logic                     enable_pcm;
    snd_audio_pkg::sample_t   snd_left;
    snd_audio_pkg::sample_t   snd_right;
    logic                     sample;
    logic                     peak;

    integer errors = 0;
    integer checks = 0;
    integer seed   = 32'h6486;

    snd_board i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one Wishbone classic access, outputs looked at on falling edges
    task automatic bus_cycle(input logic we, input snd_bus_pkg::bus_addr_t adr,
                             input snd_bus_pkg::bus_data_t dat,
                             output snd_bus_pkg::bus_data_t rdata);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(negedge clk);
        while (!wb_ack && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            errors++;
            $display("timeout: no wb_ack within 100 clocks for address %02h", adr);
        end else begin
            checks++;
            assert (n == 1) else begin
                errors++;
                $display("Fail %0t: wb_ack came %0d clocks after the request", $time, n);
            end
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!wb_ack) else begin
            errors++;
            $display("Fail %0t: wb_ack high for more than one clock at %02h", $time, adr);
        end
    endtask

    task automatic read_check(input snd_bus_pkg::bus_addr_t adr,
                              input snd_bus_pkg::bus_data_t exp);
        snd_bus_pkg::bus_data_t rdata;
        bus_cycle(1'b0, adr, 8'h00, rdata);
        checks++;
        assert (rdata == exp) else begin
            errors++;
            $display("Fail %0t: read %02h gave %02h, expected %02h", $time, adr, rdata, exp);
        end
        if (adr == snd_bus_pkg::MBOX_STATUS) begin // irq follows the full flag
            checks++;
            assert (snd_irq == exp[0]) else begin
                errors++;
                $display("Fail %0t: snd_irq is %b, expected %b", $time, snd_irq, exp[0]);
            end
        end
    endtask

    task automatic main_write(input snd_bus_pkg::bus_data_t din);
        @(posedge clk);
        main_wr  <= 1'b1;
        main_din <= din;
        @(posedge clk);
        main_wr <= 1'b0;
        @(negedge clk);
        checks++;
        assert (mbox_full && snd_irq) else begin
            errors++;
            $display("Fail %0t: mbox_full or snd_irq low after a main write", $time);
        end
    endtask

    // one sample tick and the mixed result two edges later
    task automatic tick_check(input int exp_l, input int exp_r, input logic exp_peak);
        int n;
        n = 0;
        repeat (64) @(posedge clk); // tick spacing, leaves room for the ROM fetch
        cen_snd <= 1'b1;
        @(posedge clk);
        cen_snd <= 1'b0;
        @(negedge clk);
        while (!sample && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!sample) begin
            errors++;
            $display("timeout: no sample strobe within 100 clocks after a tick");
        end else begin
            checks++;
            assert (n == 1) else begin
                errors++;
                $display("Fail %0t: sample strobe %0d clocks after the tick edge", $time, n);
            end
            checks++;
            assert (int'(snd_left) == exp_l && int'(snd_right) == exp_r &&
                    peak == exp_peak) else begin
                errors++;
                $display("Fail %0t: tick gave %0d %0d peak %b, expected %0d %0d peak %b",
                         $time, snd_left, snd_right, peak, exp_l, exp_r, exp_peak);
            end
        end
    endtask

    // sample ROM, byte is low address plus 40h
    initial begin : rom_model
        snd_audio_pkg::pcm_addr_t addr;
        int delay;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(negedge clk);
            if (rom_cs) begin
                addr  = rom_addr;
                delay = 1 + ({$random(seed)} % 7);
                repeat (delay - 1) begin
                    @(negedge clk);
                    checks++;
                    assert (rom_cs && rom_addr == addr) else begin
                        errors++;
                        $display("Fail %0t: rom_cs or rom_addr changed before rom_ok", $time);
                    end
                end
                @(posedge clk);
                rom_ok   <= 1'b1;
                rom_data <= addr[7:0] + 8'h40;
                @(posedge clk);
                rom_ok <= 1'b0;
                @(negedge clk);
                checks++;
                assert (!rom_cs) else begin
                    errors++;
                    $display("Fail %0t: rom_cs still high the clock after rom_ok", $time);
                end
            end
        end
    end

    initial begin : run
        int fd;
        int n;
        int a;
        int b;
        int c;
        int line_no;
        logic [8*120-1:0] line;
        string cmd;
        snd_bus_pkg::bus_data_t rdata;
        reset      = 1'b1;
        cen_snd    = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 8'h00;
        wb_dat_w   = 8'h00;
        main_wr    = 1'b0;
        main_din   = 8'h00;
        fxlevel    = 2'd0;
        enable_fm  = 1'b1;
        enable_pcm = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!wb_ack && !rom_cs && !sample && !peak && !mbox_full && !snd_irq &&
                snd_left == '0 && snd_right == '0) else begin
            errors++;
            $display("Fail %0t: outputs not idle after reset", $time);
        end
        fd = $fopen("testbench/snd_board_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open testbench/snd_board_vectors.txt");
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                line_no++;
                cmd = "";
                n = $sscanf(line, "%s", cmd);
                if (n < 1 || cmd.getc(0) == "#")
                    continue;
                if (cmd == "write") begin
                    n = $sscanf(line, "%s %h %h", cmd, a, b);
                    bus_cycle(1'b1, a[7:0], b[7:0], rdata);
                end else if (cmd == "read") begin
                    n = $sscanf(line, "%s %h %h", cmd, a, b);
                    read_check(a[7:0], b[7:0]);
                end else if (cmd == "main") begin
                    n = $sscanf(line, "%s %h", cmd, a);
                    main_write(a[7:0]);
                end else if (cmd == "tick") begin
                    n = $sscanf(line, "%s %d %d %d", cmd, a, b, c);
                    tick_check(a, b, c[0]);
                end else if (cmd == "opt") begin
                    n = $sscanf(line, "%s %d %d %d", cmd, a, b, c);
                    @(posedge clk);
                    fxlevel    <= a[1:0];
                    enable_fm  <= b[0];
                    enable_pcm <= c[0];
                end else begin
                    errors++;
                    $display("unknown command %s on line %0d of the vector file", cmd, line_no);
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- snd_board.f
verilog/snd_bus_pkg.sv
verilog/snd_audio_pkg.sv
verilog/snd_bus_decode.sv
verilog/snd_mailbox.sv
verilog/snd_tone.sv
verilog/snd_pcm.sv
verilog/snd_mixer.sv
verilog/snd_board.sv
testbench/snd_board_tb.sv

//--- Makefile
sim:
	verilator --binary --assert --top-module snd_board_tb -f snd_board.f
	./obj_dir/Vsnd_board_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- testbench/snd_board_vectors.txt
# write addr data | read addr expected | main byte   (hex)
# tick left right peak | opt fxlevel enable_fm enable_pcm   (decimal)
# register readback and open bus
opt 0 1 1
write 00 34
read 00 34
write 01 12
read 01 12
write 04 5a
read 04 5a
write 05 a5
read 05 a5
write 12 03
read 12 03
write 12 00
write 13 9c
read 13 9c
read 16 00
read 06 ff
read 17 ff
read 30 ff
# mailbox
main 5c
read 21 01
read 20 5c
read 21 00
# tone, left period 2 amplitude 40, right silent, fm gain only
opt 0 1 0
write 00 02
write 01 00
write 02 00
write 03 00
write 04 40
write 05 00
tick -4096 0 0
tick 4096 0 0
tick 4096 0 0
tick -4096 0 0
tick -4096 0 0
tick 4096 0 0
# pcm from 5 to 7 at fxlevel 2
opt 2 0 1
write 00 00
write 01 00
write 10 05
write 11 00
write 12 00
write 13 07
write 14 00
write 15 00
write 16 01
read 16 01
tick -7552 -7552 0
tick -7424 -7424 0
tick -7296 -7296 0
read 16 00
tick 0 0 0
# clipping at fxlevel 3 with full tone amplitude
opt 3 1 1
write 10 bf
write 13 c0
write 04 ff
write 00 01
write 01 00
write 16 01
tick 32767 32767 1
tick -32768 -32768 1
tick 16320 0 0
read 16 00
# both sources off
opt 3 0 0
write 16 01
tick 0 0 0
tick 0 0 0
tick 0 0 0
